// File: rtl/ifu_pkg.sv
package ifu_pkg;

    // data path and address width
    parameter int XLEN = 64;

    // one fetched instruction, no compressed forms
    parameter int ILEN = 32;

    // instruction memory depth, in 32-bit words
    parameter int MEM_WORDS_LOG2 = 6;
    parameter int MEM_WORDS      = 1 << MEM_WORDS_LOG2;

    // pc, addresses, immediates, register values and the read data bus
    typedef logic [XLEN-1:0] xlen_t;

    // instruction word handed to decode
    typedef logic [ILEN-1:0] inst_t;

endpackage

// File: rtl/pc_next.sv
`timescale 1ns/1ps

module pc_next #(
    parameter ifu_pkg::xlen_t RESET_VEC = 64'h8000_0000
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           stall_i,
    input  logic           fetch_done_i,
    input  logic           me_jal_i,
    input  logic           me_jalr_i,
    input  logic           me_branch_i,
    input  logic           trap_i,
    input  ifu_pkg::xlen_t me_pc_i,
    input  ifu_pkg::xlen_t me_imm_i,
    input  ifu_pkg::xlen_t me_r1data_i,
    input  ifu_pkg::xlen_t me_alu_res_i,
    input  ifu_pkg::xlen_t csr_mtvec_i,
    output ifu_pkg::xlen_t cur_pc_o
);
    import ifu_pkg::*;

    xlen_t pc_q;
    xlen_t rel_tgt;
    xlen_t jalr_sum;
    xlen_t jalr_tgt;
    logic  br_taken;

    // jal and taken branches share one target relative to the memory stage pc
    assign rel_tgt = me_pc_i + me_imm_i;

    // compare result of zero means the branch is taken
    assign br_taken = me_branch_i && (me_alu_res_i == '0);

    // jalr target with bit 0 forced low
    assign jalr_sum = me_r1data_i + me_imm_i;
    assign jalr_tgt = {jalr_sum[XLEN-1:1], 1'b0};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_VEC;
        end else if (me_jal_i || br_taken) begin
            pc_q <= rel_tgt;
        end else if (me_jalr_i) begin
            pc_q <= jalr_tgt;
        end else if (trap_i) begin
            // trap vector from the csr file
            pc_q <= csr_mtvec_i;
        end else if (fetch_done_i && !stall_i) begin
            pc_q <= pc_q + 64'd4;
        end
    end

    assign cur_pc_o = pc_q;

    // the memory stage never presents jal and jalr in the same cycle
    a_jal_jalr_onehot : assert property (
        @(posedge clk) disable iff (rst_i)
        !(me_jal_i && me_jalr_i)
    );

endmodule

// File: rtl/fetch_req.sv
`timescale 1ns/1ps

module fetch_req #(
    parameter ifu_pkg::xlen_t RESET_VEC = 64'h8000_0000
) (
    input  logic           clk,
    input  logic           rst_i,
    input  ifu_pkg::xlen_t cur_pc_i,
    output logic           mem_req_valid_o,
    output ifu_pkg::xlen_t mem_req_addr_o,
    input  logic           mem_req_ready_i,
    input  logic           mem_rsp_valid_i,
    input  ifu_pkg::xlen_t mem_rsp_data_i,
    output logic           mem_rsp_ready_o,
    output logic           fetch_done_o,
    output logic           inst_valid_o,
    output ifu_pkg::inst_t inst_o,
    output ifu_pkg::xlen_t inst_pc_o
);
    import ifu_pkg::*;

    logic  boot_q;
    logic  issue_q;
    logic  hold_q;
    xlen_t addr_q;
    logic  rsp_ready_q;
    logic  rsp_seen;
    logic  rsp_done;
    logic  deliver;
    logic  inst_valid_q;
    inst_t inst_q;
    xlen_t inst_pc_q;

    // first cycle of a request drives cur_pc directly, later cycles the latched copy
    assign mem_req_valid_o = issue_q || hold_q;
    assign mem_req_addr_o  = issue_q ? cur_pc_i : addr_q;

    // response seen for the first time, ready follows next cycle
    assign rsp_seen = mem_rsp_valid_i && !rsp_ready_q;
    assign rsp_done = mem_rsp_valid_i && rsp_ready_q;

    // a redirect may have moved the pc since this request went out
    assign deliver = rsp_seen && (addr_q == cur_pc_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            boot_q      <= 1'b1;
            issue_q     <= 1'b0;
            hold_q      <= 1'b0;
            addr_q      <= RESET_VEC;
            rsp_ready_q <= 1'b0;
        end else begin
            boot_q <= 1'b0;
            // one request in flight, the next one starts after completion
            issue_q <= boot_q || rsp_done;
            hold_q  <= mem_req_valid_o && !mem_req_ready_i;
            if (issue_q) begin
                addr_q <= cur_pc_i;
            end
            rsp_ready_q <= rsp_seen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= deliver;
        end
    end

    // payload only moves on a delivery
    always_ff @(posedge clk) begin
        if (deliver) begin
            inst_q    <= mem_rsp_data_i[ILEN-1:0];
            inst_pc_q <= addr_q;
        end
    end

    assign mem_rsp_ready_o = rsp_ready_q;
    assign inst_valid_o    = inst_valid_q;
    assign fetch_done_o    = inst_valid_q;
    assign inst_o          = inst_q;
    assign inst_pc_o       = inst_pc_q;

    // address held until the memory takes it
    a_req_addr_stable : assert property (
        @(posedge clk) disable iff (rst_i)
        mem_req_valid_o && !mem_req_ready_i |=>
            mem_req_valid_o && $stable(mem_req_addr_o)
    );

    // ready pulse only lands on a held response
    a_rsp_ready_with_valid : assert property (
        @(posedge clk) disable iff (rst_i)
        mem_rsp_ready_o |-> mem_rsp_valid_i
    );

endmodule

// File: rtl/inst_mem.sv
`timescale 1ns/1ps

module inst_mem #(
    parameter int unsigned MEM_LATENCY = 2
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           req_valid_i,
    input  ifu_pkg::xlen_t req_addr_i,
    output logic           req_ready_o,
    input  logic           rsp_ready_i,
    output logic           rsp_valid_o,
    output ifu_pkg::xlen_t rsp_data_o
);
    import ifu_pkg::*;

    localparam int LAT_W = $clog2(MEM_LATENCY + 1);

    inst_t                     mem [0:MEM_WORDS-1];
    logic  [MEM_WORDS_LOG2-1:0] idx;
    logic                      busy_q;
    logic                      rsp_valid_q;
    logic  [LAT_W-1:0]         cnt_q;
    xlen_t                     rsp_data_q;
    logic                      req_fire;
    logic                      rsp_fire;

    initial begin
        $readmemh("prog.hex", mem);
    end

    // word index, wraps at the memory depth
    assign idx = req_addr_i[MEM_WORDS_LOG2+1:2];

    assign req_ready_o = !busy_q;
    assign req_fire    = req_valid_i && req_ready_o;
    assign rsp_fire    = rsp_valid_q && rsp_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
            cnt_q       <= '0;
        end else if (req_fire) begin
            busy_q      <= 1'b1;
            cnt_q       <= LAT_W'(MEM_LATENCY - 1);
            // single cycle latency answers straight away
            rsp_valid_q <= (MEM_LATENCY == 1);
        end else if (busy_q && !rsp_valid_q) begin
            if (cnt_q == LAT_W'(1)) begin
                rsp_valid_q <= 1'b1;
            end
            cnt_q <= cnt_q - LAT_W'(1);
        end else if (rsp_fire) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end
    end

    // read at accept, upper half of the bus is zero
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_data_q <= {{(XLEN-ILEN){1'b0}}, mem[idx]};
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;

    // back-pressure holds the response, nothing is dropped
    a_rsp_held : assert property (
        @(posedge clk) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o)
    );

endmodule

// File: rtl/ifu_top.sv
`timescale 1ns/1ps

module ifu_top #(
    parameter ifu_pkg::xlen_t RESET_VEC   = 64'h8000_0000,
    parameter int unsigned    MEM_LATENCY = 2
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           pc_stall_i,
    input  logic           me_jal_i,
    input  logic           me_jalr_i,
    input  logic           me_branch_i,
    input  logic           trap_i,
    input  ifu_pkg::xlen_t me_pc_i,
    input  ifu_pkg::xlen_t me_imm_i,
    input  ifu_pkg::xlen_t me_r1data_i,
    input  ifu_pkg::xlen_t me_alu_res_i,
    input  ifu_pkg::xlen_t csr_mtvec_i,
    output logic           inst_valid_o,
    output ifu_pkg::inst_t inst_o,
    output ifu_pkg::xlen_t inst_pc_o
);
    import ifu_pkg::*;

    xlen_t cur_pc;
    logic  fetch_done;

    // memory request and response channels
    logic  mem_req_valid;
    xlen_t mem_req_addr;
    logic  mem_req_ready;
    logic  mem_rsp_valid;
    xlen_t mem_rsp_data;
    logic  mem_rsp_ready;

    pc_next #(
        .RESET_VEC (RESET_VEC)
    ) u_pc_next (
        .clk          (clk),
        .rst_i        (rst_i),
        .stall_i      (pc_stall_i),
        .fetch_done_i (fetch_done),
        .me_jal_i     (me_jal_i),
        .me_jalr_i    (me_jalr_i),
        .me_branch_i  (me_branch_i),
        .trap_i       (trap_i),
        .me_pc_i      (me_pc_i),
        .me_imm_i     (me_imm_i),
        .me_r1data_i  (me_r1data_i),
        .me_alu_res_i (me_alu_res_i),
        .csr_mtvec_i  (csr_mtvec_i),
        .cur_pc_o     (cur_pc)
    );

    fetch_req #(
        .RESET_VEC (RESET_VEC)
    ) u_fetch_req (
        .clk             (clk),
        .rst_i           (rst_i),
        .cur_pc_i        (cur_pc),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_addr_o  (mem_req_addr),
        .mem_req_ready_i (mem_req_ready),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_data_i  (mem_rsp_data),
        .mem_rsp_ready_o (mem_rsp_ready),
        .fetch_done_o    (fetch_done),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o),
        .inst_pc_o       (inst_pc_o)
    );

    inst_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_inst_mem (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (mem_req_valid),
        .req_addr_i  (mem_req_addr),
        .req_ready_o (mem_req_ready),
        .rsp_ready_i (mem_rsp_ready),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_data_o  (mem_rsp_data)
    );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: sim/tb_ifu_top.sv
`timescale 1ns/1ps

module tb_ifu_top;
    import ifu_pkg::*;

    localparam xlen_t       RESET_VEC   = 64'h8000_0000;
    localparam int unsigned MEM_LATENCY = 3;

    // deliveries expected in each phase
    localparam int SEQ_RUN    = 10;
    localparam int ROUNDS     = 14;
    localparam int MAX_GAP    = 4;
    localparam int STALL_REPS = 4;
    localparam int RESUME_RUN = 3;
    localparam int N_DELIV    = SEQ_RUN + ROUNDS * (MAX_GAP + 1) + STALL_REPS + RESUME_RUN;
    localparam int TIMEOUT    = 40 * N_DELIV * (int'(MEM_LATENCY) + 3);

    logic  clk;
    logic  rst_i;
    logic  pc_stall;
    logic  me_jal;
    logic  me_jalr;
    logic  me_branch;
    logic  trap;
    xlen_t me_pc;
    xlen_t me_imm;
    xlen_t me_r1data;
    xlen_t me_alu_res;
    xlen_t csr_mtvec;
    logic  inst_valid;
    inst_t inst;
    xlen_t inst_pc;

    // mirror of the instruction memory and the reference pc
    inst_t prog [0:(1 << MEM_WORDS_LOG2)-1];
    xlen_t exp_pc;
    int    seed;
    int    cycles = 0;

    tb_clock u_tb_clock (.clk(clk));

    ifu_top #(
        .RESET_VEC   (RESET_VEC),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_ifu_top (
        .clk          (clk),
        .rst_i        (rst_i),
        .pc_stall_i   (pc_stall),
        .me_jal_i     (me_jal),
        .me_jalr_i    (me_jalr),
        .me_branch_i  (me_branch),
        .trap_i       (trap),
        .me_pc_i      (me_pc),
        .me_imm_i     (me_imm),
        .me_r1data_i  (me_r1data),
        .me_alu_res_i (me_alu_res),
        .csr_mtvec_i  (csr_mtvec),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .inst_pc_o    (inst_pc)
    );

    task automatic fail_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input xlen_t expected, input xlen_t actual);
        $display("ERROR: %s %s expected %h actual %h", test, field, expected, actual);
        fail_run();
    endtask

    // word-aligned address in a 2 KiB window above the reset vector
    function automatic xlen_t random_target();
        int unsigned r;
        r = $unsigned($random(seed));
        return RESET_VEC + xlen_t'((r % 512) * 4);
    endfunction

    // word-aligned offset between -64 and +60
    function automatic xlen_t branch_offset();
        int off;
        off = (int'($unsigned($random(seed)) % 32) - 16) * 4;
        return xlen_t'(longint'(off));
    endfunction

    task automatic next_delivery(input string test);
        inst_t exp_inst;
        @(posedge clk);
        while (!inst_valid) begin
            @(posedge clk);
        end
        exp_inst = prog[int'((exp_pc >> 2) % xlen_t'(1 << MEM_WORDS_LOG2))];
        assert (inst_pc == exp_pc)
            else report_mismatch(test, "pc", exp_pc, inst_pc);
        assert (inst == exp_inst)
            else report_mismatch(test, "inst", xlen_t'(exp_inst), xlen_t'(inst));
        // a stalled delivery fetches the same pc again
        if (!pc_stall) begin
            exp_pc = exp_pc + 64'd4;
        end
    endtask

    task automatic redirect(input string test, input logic jal, input logic jalr,
                            input logic branch, input logic taken, input logic trp);
        xlen_t base;
        xlen_t offset;
        xlen_t reg_val;
        xlen_t vec;
        base    = random_target();
        offset  = branch_offset();
        reg_val = random_target() | 64'd1;
        vec     = random_target();
        me_pc      <= base;
        me_imm     <= offset;
        me_r1data  <= reg_val;
        me_alu_res <= taken ? 64'd0 : base;
        csr_mtvec  <= vec;
        me_jal     <= jal;
        me_jalr    <= jalr;
        me_branch  <= branch;
        trap       <= trp;
        // jal and taken branches first, then jalr, then trap
        if (jal || (branch && taken)) begin
            exp_pc = base + offset;
        end else if (jalr) begin
            exp_pc = (reg_val + offset) & ~64'd1;
        end else if (trp) begin
            exp_pc = vec;
        end
        @(posedge clk);
        me_jal    <= 1'b0;
        me_jalr   <= 1'b0;
        me_branch <= 1'b0;
        trap      <= 1'b0;
        next_delivery(test);
    endtask

    initial begin
        int gap;
        seed   = 32'hf0a649fe;
        exp_pc = RESET_VEC;
        $readmemh("prog.hex", prog);
        rst_i      <= 1'b1;
        pc_stall   <= 1'b0;
        me_jal     <= 1'b0;
        me_jalr    <= 1'b0;
        me_branch  <= 1'b0;
        trap       <= 1'b0;
        me_pc      <= '0;
        me_imm     <= '0;
        me_r1data  <= '0;
        me_alu_res <= '0;
        csr_mtvec  <= '0;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;

        repeat (SEQ_RUN) next_delivery("sequential");

        // redirects land in the cycle after a delivery
        for (int r = 0; r < ROUNDS; r++) begin
            case (r % 7)
                0: redirect("jal", 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
                1: redirect("branch_taken", 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
                2: redirect("branch_not_taken", 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                3: redirect("jalr", 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
                4: redirect("jalr_over_trap", 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
                5: redirect("trap", 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                default: redirect("branch_over_trap", 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
            endcase
            gap = 1 + int'($unsigned($random(seed)) % MAX_GAP);
            repeat (gap) next_delivery("sequential");
        end

        pc_stall <= 1'b1;
        repeat (STALL_REPS) next_delivery("stall");
        pc_stall <= 1'b0;
        repeat (RESUME_RUN) next_delivery("stall_release");

        $display("Result: PASSED");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles while waiting for a delivery", cycles);
            fail_run();
        end
    end

endmodule

// File: ifu_subsys.f
rtl/ifu_pkg.sv
rtl/pc_next.sv
rtl/fetch_req.sv
rtl/inst_mem.sv
rtl/ifu_top.sv
sim/tb_clock.sv
sim/tb_ifu_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_ifu_top
FILELIST  := ifu_subsys.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# runs from the project root so that prog.hex is found
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: prog.hex
// one 32-bit instruction word per line, word index 0 to 63
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
01900c93
01a00d13
01b00d93
01c00e13
01d00e93
01e00f13
01f00f93
00000013
001080b3
00110133
001181b3
00120233
001282b3
00130333
001383b3
00140433
001484b3
00150533
001585b3
00160633
001686b3
00170733
001787b3
00180833
001888b3
00190933
001989b3
001a0a33
001a8ab3
001b0b33
001b8bb3
001c0c33
001c8cb3
001d0d33
001d8db3
001e0e33
001e8eb3
001f0f33
001f8fb3
00000073
